/* Bender.yml */
package:
  name: credit_link

sources:
  - src/credit_link_pkg.sv
  - src/credit_sender.sv
  - src/credit_receiver.sv
  - src/rx_fifo.sv
  - src/credit_link_top.sv
  - target: test
    files:
      - bench/credit_link_tb.sv

/* bench/credit_link_tb.sv */
// Credit link testbench
`timescale 1ns/1ps
`default_nettype none

module credit_link_tb
  import credit_link_pkg::*;
();

  // Roughly four times the stimulus length
  localparam int TIMEOUT_CYCLES = 3000;
  // Long enough for every held credit to be spent
  localparam int BURST_WINDOW   = 20;

  logic    clk;
  logic    rst;
  logic    src_valid;
  flit_t   src_flit;
  logic    credit_ok;
  logic    pop;
  logic    pop_valid;
  flit_t   pop_flit;
  credit_t credit_initial;
  credit_t credit_withhold;
  credit_t credit_count;
  credit_t credit_available;

  // Scoreboard, oldest unpopped flit at the front
  flit_t expected_q[$];
  int    sent_total;
  int    popped_total;
  int    cycle_count;

  credit_link_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped on timeout");
    end
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  // Inputs change 1 ns past the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Falling edge sees settled outputs and scoreboard
  always @(negedge clk) begin
    if (!rst) begin
      assert (credit_available <= credit_count)
        else report_mismatch($sformatf("credit_available %0d above credit_count %0d",
                                       credit_available, credit_count));
      // Outstanding flits bounded by the loaded credits
      assert (expected_q.size() <= int'(credit_initial))
        else report_mismatch($sformatf("%0d flits outstanding with %0d credits",
                                       expected_q.size(), credit_initial));
    end
  end

  task automatic apply_reset(input credit_t init_val, input credit_t hold_val);
    next_cycle();
    rst             = 1'b1;
    src_valid       = 1'b0;
    pop             = 1'b0;
    credit_initial  = init_val;
    credit_withhold = hold_val;
    repeat (5) next_cycle();
    rst = 1'b0;
  endtask

  // First credit must come back soon after the load cycle
  task automatic wait_credit();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 8 && !seen; i++) begin
      next_cycle();
      seen = credit_ok;
    end
    assert (seen) else report_failure("credit_ok did not rise within 8 cycles of reset");
  endtask

  task automatic send_flit();
    flit_t f;
    f.data    = DATA_WIDTH'($urandom);
    f.last    = 1'($urandom_range(0, 1));
    src_flit  = f;
    src_valid = 1'b1;
    expected_q.push_back(f);
    sent_total++;
  endtask

  // Compare the head flit and strobe pop for this cycle
  task automatic take_head();
    flit_t exp_flit;
    if (expected_q.size() == 0) begin
      report_failure("pop_valid high with no flit outstanding");
    end else begin
      exp_flit = expected_q.pop_front();
      assert (pop_flit === exp_flit)
        else report_mismatch($sformatf("popped data %h last %b, expected data %h last %b",
                                       pop_flit.data, pop_flit.last,
                                       exp_flit.data, exp_flit.last));
      popped_total++;
      pop = 1'b1;
    end
  endtask

  // Strobe whenever a credit is held, no pops
  task automatic send_burst(input int window, output int accepted);
    accepted = 0;
    repeat (window) begin
      next_cycle();
      src_valid = 1'b0;
      if (credit_ok) begin
        send_flit();
        accepted++;
      end
    end
    next_cycle();
    src_valid = 1'b0;
  endtask

  task automatic drain_fifo();
    while (expected_q.size() > 0) begin
      next_cycle();
      pop = 1'b0;
      if (pop_valid) take_head();
    end
    next_cycle();
    pop = 1'b0;
  endtask

  task automatic random_traffic(input int cycles);
    repeat (cycles) begin
      next_cycle();
      pop       = 1'b0;
      src_valid = 1'b0;
      if (pop_valid && $urandom_range(0, 2) != 0) take_head();
      if (credit_ok && $urandom_range(0, 1) == 1) send_flit();
    end
    next_cycle();
    pop       = 1'b0;
    src_valid = 1'b0;
  endtask

  initial begin
    credit_t init_cfg;
    credit_t hold_cfg;
    credit_t pool_exp;
    credit_t pool_seen;
    int      accepted;
    void'($urandom(76));
    rst             = 1'b1;
    src_valid       = 1'b0;
    src_flit        = '0;
    pop             = 1'b0;
    credit_initial  = '0;
    credit_withhold = '0;
    sent_total      = 0;
    popped_total    = 0;
    cycle_count     = 0;

    // Full credit pool, nothing withheld
    apply_reset(credit_t'(4), credit_t'(0));
    assert (credit_ok === 1'b0) else report_mismatch("credit_ok high right after reset");
    assert (pop_valid === 1'b0) else report_mismatch("pop_valid high right after reset");
    wait_credit();
    send_burst(BURST_WINDOW, accepted);
    assert (accepted == 4)
      else report_mismatch($sformatf("%0d strobes accepted, expected 4", accepted));
    assert (credit_ok === 1'b0) else report_mismatch("credit_ok still high with no pops");
    drain_fifo();

    // Two of four credits held back
    apply_reset(credit_t'(4), credit_t'(2));
    wait_credit();
    send_burst(BURST_WINDOW, accepted);
    assert (accepted == 2)
      else report_mismatch($sformatf("%0d strobes accepted, expected 2", accepted));
    drain_fifo();

    // Random traffic on a random configuration
    init_cfg = credit_t'(2 + $urandom_range(0, 2));
    hold_cfg = credit_t'($urandom_range(0, 1));
    apply_reset(init_cfg, hold_cfg);
    wait_credit();
    random_traffic(500);
    drain_fifo();
    repeat (10) next_cycle();
    // Every sent flit is gone, so the FIFO must read empty
    assert (pop_valid === 1'b0)
      else report_mismatch($sformatf("pop_valid high after drain, sent %0d popped %0d",
                                     sent_total, popped_total));
    // Pool settles at the withheld level once all returns are done
    pool_exp = (init_cfg > hold_cfg) ? hold_cfg : init_cfg;
    assert (credit_count == pool_exp)
      else report_mismatch($sformatf("credit_count %0d, expected %0d", credit_count, pool_exp));
    assert (credit_ok === (init_cfg > hold_cfg))
      else report_mismatch("credit_ok wrong after drain");
    // Sender-held credits show up as strobes it can still take
    pool_seen = credit_count;
    send_burst(BURST_WINDOW, accepted);
    assert (int'(pool_seen) + accepted == int'(init_cfg))
      else report_mismatch($sformatf("pool %0d plus sender %0d, expected %0d",
                                     pool_seen, accepted, init_cfg));
    drain_fifo();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule : credit_link_tb

`default_nettype wire

/* credit_link.f */
src/credit_link_pkg.sv
src/credit_sender.sv
src/credit_receiver.sv
src/rx_fifo.sv
src/credit_link_top.sv
bench/credit_link_tb.sv

/* src/credit_link_pkg.sv */
// Credit link shared definitions
`default_nettype none

package credit_link_pkg;

  // Flit payload width
  localparam int DATA_WIDTH = 8;

  // Largest credit count a link may hold
  // Also the receive FIFO depth
  localparam int MAX_CREDIT = 4;

  // Holds 0 through MAX_CREDIT inclusive
  localparam int CREDIT_WIDTH = $clog2(MAX_CREDIT + 1);

  // Receive FIFO pointer width
  localparam int PTR_WIDTH = $clog2(MAX_CREDIT);

  // One flit on the link
  // The last marker rides along untouched
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } flit_t;

  // Any credit count or credit port
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

  // Receiver phases
  typedef enum logic {
    // First cycle out of reset, initial credits captured
    RX_LOAD,
    // Normal operation, credits handed back
    RX_ACTIVE
  } rx_state_t;

  // Handy constants for credit arithmetic
  localparam credit_t CREDIT_ONE  = credit_t'(1);
  localparam credit_t CREDIT_ZERO = credit_t'(0);
  localparam credit_t CREDIT_MAX  = credit_t'(MAX_CREDIT);

endpackage : credit_link_pkg

`default_nettype wire

/* src/credit_link_top.sv */
// Credit link top
`timescale 1ns/1ps
`default_nettype none

module credit_link_top
  import credit_link_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,

  // Producer
  input  wire logic    src_valid,
  input  wire flit_t   src_flit,
  output logic         credit_ok,

  // Consumer
  input  wire logic    pop,
  output logic         pop_valid,
  output flit_t        pop_flit,

  // Credit configuration and status
  input  wire credit_t credit_initial,
  input  wire credit_t credit_withhold,
  output credit_t      credit_count,
  output credit_t      credit_available
);

  // Link wires
  logic  push_valid;
  flit_t push_flit;
  logic  push_credit;

  // FIFO to receiver
  logic  fifo_pop_done;

  credit_sender u_sender (
    .clk         (clk),
    .rst         (rst),
    .src_valid   (src_valid),
    .src_flit    (src_flit),
    .credit_ok   (credit_ok),
    .push_credit (push_credit),
    .push_valid  (push_valid),
    .push_flit   (push_flit)
  );

  credit_receiver u_receiver (
    .clk              (clk),
    .rst              (rst),
    .push_valid       (push_valid),
    .push_credit      (push_credit),
    .fifo_pop_done    (fifo_pop_done),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  rx_fifo u_fifo (
    .clk           (clk),
    .rst           (rst),
    .push_valid    (push_valid),
    .push_flit     (push_flit),
    .pop           (pop),
    .pop_valid     (pop_valid),
    .pop_flit      (pop_flit),
    .fifo_pop_done (fifo_pop_done)
  );

endmodule : credit_link_top

`default_nettype wire

/* src/credit_receiver.sv */
// Credit receiver
`timescale 1ns/1ps
`default_nettype none

module credit_receiver
  import credit_link_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,

  // Link side
  input  wire logic    push_valid,
  output logic         push_credit,

  // Consumer drained one slot
  input  wire logic    fifo_pop_done,

  // Credit configuration
  input  wire credit_t credit_initial,
  input  wire credit_t credit_withhold,

  // Pool status
  output credit_t      credit_count,
  output credit_t      credit_available
);

  rx_state_t state;

  // Free slots not yet handed back to the sender
  credit_t pool;
  credit_t pool_next;

  // Captured credit_initial, the upper bound for the link
  credit_t max_credit;

  // Credits on the sender side, in flight or held
  credit_t held;
  credit_t held_next;

  // Hand back one credit this cycle
  logic do_return;

  // Only above the withheld level, and never during load
  assign do_return = (state == RX_ACTIVE) && (pool > credit_withhold);

  always_comb begin
    pool_next = pool;
    if (state == RX_LOAD) begin
      pool_next = credit_initial;
    end else if (fifo_pop_done && !do_return) begin
      pool_next = pool + CREDIT_ONE;
    end else if (!fifo_pop_done && do_return) begin
      pool_next = pool - CREDIT_ONE;
    end
  end

  // Mirror of the sender count, up on return, down on push
  always_comb begin
    held_next = held;
    if (push_credit && !push_valid) begin
      held_next = held + CREDIT_ONE;
    end else if (!push_credit && push_valid) begin
      held_next = held - CREDIT_ONE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= RX_LOAD;
      pool        <= CREDIT_ZERO;
      max_credit  <= CREDIT_ZERO;
      held        <= CREDIT_ZERO;
      push_credit <= 1'b0;
    end else begin
      // Load lasts exactly one cycle
      state       <= RX_ACTIVE;
      pool        <= pool_next;
      held        <= held_next;
      push_credit <= do_return;
      if (state == RX_LOAD) begin
        max_credit <= credit_initial;
      end
    end
  end

  assign credit_count     = pool;
  assign credit_available = (pool > credit_withhold) ? (pool - credit_withhold) : CREDIT_ZERO;

  // Sender never holds more than was loaded
  a_held_bound: assert property (
    @(posedge clk) disable iff (rst)
    held <= max_credit
  ) else $error("credit_receiver: sender-held credits above maximum");

  a_withhold_range: assert property (
    @(posedge clk) disable iff (rst)
    credit_withhold <= CREDIT_MAX
  ) else $error("credit_receiver: credit_withhold above MAX_CREDIT");

  // A push needs a credit earlier given to the sender
  a_no_push_without_credit: assert property (
    @(posedge clk) disable iff (rst)
    push_valid |-> (held != CREDIT_ZERO)
  ) else $error("credit_receiver: push with no sender credit");

endmodule : credit_receiver

`default_nettype wire

/* src/credit_sender.sv */
// Credit sender
`timescale 1ns/1ps
`default_nettype none

module credit_sender
  import credit_link_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,

  // Producer side
  input  wire logic  src_valid,
  input  wire flit_t src_flit,
  output logic       credit_ok,

  // Link side
  input  wire logic  push_credit,
  output logic       push_valid,
  output flit_t      push_flit
);

  // Credits currently held by the sender
  credit_t credit_cnt;
  credit_t credit_cnt_next;

  // Producer strobe taken this cycle
  logic accept;

  // Producer may only strobe while a credit is held
  assign credit_ok = (credit_cnt != CREDIT_ZERO);
  assign accept    = src_valid && credit_ok;

  // Return and spend may land together, then the count holds
  always_comb begin
    credit_cnt_next = credit_cnt;
    if (push_credit && !accept) begin
      credit_cnt_next = credit_cnt + CREDIT_ONE;
    end else if (!push_credit && accept) begin
      credit_cnt_next = credit_cnt - CREDIT_ONE;
    end
  end

  // Credit counter and link strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= CREDIT_ZERO;
      push_valid <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt_next;
      push_valid <= accept;
    end
  end

  // Flit register, loaded only on an accepted strobe
  // push_valid qualifies it on the link
  always_ff @(posedge clk) begin
    if (accept) begin
      push_flit <= src_flit;
    end
  end

  // Producer must wait for credit
  a_no_strobe_without_credit: assert property (
    @(posedge clk) disable iff (rst)
    src_valid |-> (credit_cnt != CREDIT_ZERO)
  ) else $error("credit_sender: src_valid with zero credits");

  // Receiver never returns more than the link can hold
  a_credit_cnt_bound: assert property (
    @(posedge clk) disable iff (rst)
    credit_cnt <= CREDIT_MAX
  ) else $error("credit_sender: credit count above MAX_CREDIT");

endmodule : credit_sender

`default_nettype wire

/* src/rx_fifo.sv */
// Receive FIFO
`timescale 1ns/1ps
`default_nettype none

module rx_fifo
  import credit_link_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,

  // Write side, straight off the link
  input  wire logic  push_valid,
  input  wire flit_t push_flit,

  // Consumer side
  input  wire logic  pop,
  output logic       pop_valid,
  output flit_t      pop_flit,

  // Slot freed, goes to the receiver
  output logic       fifo_pop_done
);

  localparam logic [PTR_WIDTH-1:0] PTR_LAST = PTR_WIDTH'(MAX_CREDIT - 1);

  // Storage, no reset on payload
  flit_t mem [MAX_CREDIT];

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  credit_t              count;

  assign pop_valid     = (count != CREDIT_ZERO);
  assign pop_flit      = mem[rd_ptr];
  assign fifo_pop_done = pop && pop_valid;

  always_ff @(posedge clk) begin
    if (push_valid) begin
      mem[wr_ptr] <= push_flit;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= CREDIT_ZERO;
    end else begin
      if (push_valid) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (fifo_pop_done) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      if (push_valid && !fifo_pop_done) begin
        count <= count + CREDIT_ONE;
      end else if (!push_valid && fifo_pop_done) begin
        count <= count - CREDIT_ONE;
      end
    end
  end

  // Credits equal free slots, so a full FIFO sees no push
  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst)
    push_valid |-> (count < CREDIT_MAX)
  ) else $error("rx_fifo: push while full");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> pop_valid
  ) else $error("rx_fifo: pop while empty");

endmodule : rx_fifo

`default_nettype wire
